//--- logic/uart_msg_defs.svh
`ifndef UART_MSG_DEFS_SVH
`define UART_MSG_DEFS_SVH

// FIFO entries between sender and transmitter
`define UART_FIFO_DEPTH 16

// Greeting plus CR LF
`define UART_MSG_LEN 15

// Clock cycles per bit
`define UART_BAUD_DIV_RESET 16
`define UART_BAUD_DIV_MIN 4

// Register map
`define UART_ADDR_BAUD 0
`define UART_ADDR_CTRL 1
`define UART_ADDR_START 2

`endif

//--- logic/uart_msg_pkg.sv
`include "uart_msg_defs.svh"

package uart_msg_pkg;

  typedef logic [7:0] byte_t;

  typedef logic [15:0] baud_div_t; // Clock cycles per bit

  typedef logic [1:0] cfg_addr_t;

  typedef logic [$clog2(`UART_MSG_LEN)-1:0] msg_ptr_t; // Index into the message ROM

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  typedef enum logic {
    SEND_IDLE,
    SEND_WRITE
  } send_state_t;

endpackage

//--- logic/byte_fifo_if.sv
`timescale 1ns/1ps

interface byte_fifo_if;
  import uart_msg_pkg::*;

  logic  wr_en;
  byte_t wr_data;
  logic  full;
  logic  rd_en;
  byte_t rd_data; // Head entry, valid while empty is low
  logic  empty;

  modport writer (
    output wr_en, wr_data,
    input  full
  );

  modport reader (
    output rd_en,
    input  rd_data, empty
  );

  modport storage (
    input  wr_en, wr_data, rd_en,
    output full, rd_data, empty
  );

endinterface

//--- logic/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
  parameter int DEPTH = 16
) (
  input logic         CLK,
  input logic         reset,
  byte_fifo_if.storage fifo
);
  import uart_msg_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  byte_t             mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_wr;
  logic              do_rd;

  assign do_wr = fifo.wr_en && !fifo.full; // Write to a full FIFO is dropped
  assign do_rd = fifo.rd_en && !fifo.empty; // Read of an empty FIFO is dropped

  always_ff @(posedge CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= fifo.wr_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign fifo.empty   = (count == '0);
  assign fifo.full    = (count == CNT_W'(DEPTH));
  assign fifo.rd_data = mem[rd_ptr]; // First word fall through

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic                  CLK,
  input  logic                  reset,
  input  uart_msg_pkg::baud_div_t baud_div,
  byte_fifo_if.reader           fifo,
  output logic                  tx,
  output logic                  tx_active
);
  import uart_msg_pkg::*;

  tx_state_t state;
  baud_div_t div_q;    // Divisor latched per frame
  baud_div_t bit_cnt;
  logic [2:0] bit_idx;
  byte_t     shift;
  logic      pop;      // Registered read strobe, doubles as capture flag
  logic      bit_end;

  assign bit_end = (bit_cnt == div_q - 1'b1);

  always_ff @(posedge CLK) begin
    if (reset) begin
      state   <= TX_IDLE;
      pop     <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          bit_cnt <= '0;
          bit_idx <= '0;
          if (pop) begin
            pop   <= 1'b0;
            state <= TX_START; // Head is captured on this edge
          end else if (!fifo.empty) begin
            pop <= 1'b1;
          end
        end
        TX_START: begin
          if (bit_end) begin
            bit_cnt <= '0;
            state   <= TX_DATA;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= TX_STOP;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            bit_cnt <= '0;
            state   <= TX_IDLE;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Frame payload
  always_ff @(posedge CLK) begin
    if (state == TX_IDLE && pop) begin
      shift <= fifo.rd_data;
      div_q <= baud_div;
    end else if (state == TX_DATA && bit_end) begin
      shift <= shift >> 1; // LSB first
    end
  end

  assign fifo.rd_en = pop;

  always_comb begin
    case (state)
      TX_START: tx = 1'b0;
      TX_DATA:  tx = shift[0];
      default:  tx = 1'b1; // Idle and stop level
    endcase
  end

  assign tx_active = (state != TX_IDLE);

endmodule

//--- logic/msg_sender.sv
`timescale 1ns/1ps
`include "uart_msg_defs.svh"

module msg_sender (
  input  logic        CLK,
  input  logic        reset,
  input  logic        start,
  input  logic        repeat_en,
  byte_fifo_if.writer fifo,
  output logic        active,
  output logic        msg_done
);
  import uart_msg_pkg::*;

  send_state_t state;
  msg_ptr_t    idx;
  byte_t       rom_byte;
  logic        last;

  // Greeting ROM
  always_comb begin
    case (idx)
      4'd0:    rom_byte = "H";
      4'd1:    rom_byte = "e";
      4'd2:    rom_byte = "l";
      4'd3:    rom_byte = "l";
      4'd4:    rom_byte = "o";
      4'd5:    rom_byte = ",";
      4'd6:    rom_byte = " ";
      4'd7:    rom_byte = "F";
      4'd8:    rom_byte = "i";
      4'd9:    rom_byte = "f";
      4'd10:   rom_byte = "o";
      4'd11:   rom_byte = "!";
      4'd12:   rom_byte = "!";
      4'd13:   rom_byte = 8'h0d; // CR
      4'd14:   rom_byte = 8'h0a; // LF
      default: rom_byte = 8'h00;
    endcase
  end

  assign fifo.wr_en   = (state == SEND_WRITE) && !fifo.full; // Stall on full
  assign fifo.wr_data = rom_byte;
  assign last         = (idx == msg_ptr_t'(`UART_MSG_LEN - 1));

  always_ff @(posedge CLK) begin
    if (reset) begin
      state    <= SEND_IDLE;
      idx      <= '0;
      msg_done <= 1'b0;
    end else begin
      msg_done <= 1'b0;
      case (state)
        SEND_IDLE: begin
          idx <= '0;
          if (start || (msg_done && repeat_en)) begin
            state <= SEND_WRITE;
          end
        end
        SEND_WRITE: begin
          if (fifo.wr_en) begin
            if (last) begin
              idx      <= '0;
              msg_done <= 1'b1;
              state    <= SEND_IDLE;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        default: state <= SEND_IDLE;
      endcase
    end
  end

  assign active = (state == SEND_WRITE);

endmodule

//--- logic/tx_config.sv
`timescale 1ns/1ps
`include "uart_msg_defs.svh"

module tx_config (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic                    cfg_wr,
  input  uart_msg_pkg::cfg_addr_t cfg_addr,
  input  logic [15:0]             cfg_wdata,
  output logic [15:0]             cfg_rdata,
  output uart_msg_pkg::baud_div_t baud_div,
  output logic                    repeat_en,
  output logic                    start
);
  import uart_msg_pkg::*;

  localparam baud_div_t DIV_MIN = baud_div_t'(`UART_BAUD_DIV_MIN);

  logic wr_baud;
  logic wr_ctrl;
  logic wr_start;

  assign wr_baud  = cfg_wr && (cfg_addr == cfg_addr_t'(`UART_ADDR_BAUD));
  assign wr_ctrl  = cfg_wr && (cfg_addr == cfg_addr_t'(`UART_ADDR_CTRL));
  assign wr_start = cfg_wr && (cfg_addr == cfg_addr_t'(`UART_ADDR_START));

  always_ff @(posedge CLK) begin
    if (reset) begin
      baud_div  <= baud_div_t'(`UART_BAUD_DIV_RESET);
      repeat_en <= 1'b0;
      start     <= 1'b0;
    end else begin
      start <= wr_start; // Single-cycle pulse, nothing stored
      if (wr_baud) begin
        baud_div <= (cfg_wdata < DIV_MIN) ? DIV_MIN : cfg_wdata;
      end
      if (wr_ctrl) begin
        repeat_en <= cfg_wdata[0];
      end
    end
  end

  // Read-back
  always_comb begin
    case (cfg_addr)
      cfg_addr_t'(`UART_ADDR_BAUD): cfg_rdata = baud_div;
      cfg_addr_t'(`UART_ADDR_CTRL): cfg_rdata = {15'b0, repeat_en};
      default:                      cfg_rdata = '0;
    endcase
  end

endmodule

//--- logic/uart_msg_top.sv
`timescale 1ns/1ps
`include "uart_msg_defs.svh"

module uart_msg_top (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic                    cfg_wr,
  input  uart_msg_pkg::cfg_addr_t cfg_addr,
  input  logic [15:0]             cfg_wdata,
  output logic [15:0]             cfg_rdata,
  output logic                    uart_tx,
  output logic                    busy,
  output logic                    msg_done
);
  import uart_msg_pkg::*;

  baud_div_t baud_div;
  logic      repeat_en;
  logic      start;
  logic      sender_active;
  logic      tx_active;

  byte_fifo_if fifo_bus ();

  tx_config i_tx_config (
    .CLK       (CLK),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .baud_div  (baud_div),
    .repeat_en (repeat_en),
    .start     (start)
  );

  msg_sender i_msg_sender (
    .CLK       (CLK),
    .reset     (reset),
    .start     (start),
    .repeat_en (repeat_en),
    .fifo      (fifo_bus.writer),
    .active    (sender_active),
    .msg_done  (msg_done)
  );

  byte_fifo #(
    .DEPTH (`UART_FIFO_DEPTH)
  ) i_byte_fifo (
    .CLK   (CLK),
    .reset (reset),
    .fifo  (fifo_bus.storage)
  );

  uart_tx i_uart_tx (
    .CLK       (CLK),
    .reset     (reset),
    .baud_div  (baud_div),
    .fifo      (fifo_bus.reader),
    .tx        (uart_tx),
    .tx_active (tx_active)
  );

  assign busy = sender_active || !fifo_bus.empty || tx_active; // Any stage still working

endmodule

//--- tb/uart_msg_chk.sv
`timescale 1ns/1ps
`include "uart_msg_defs.svh"

module uart_msg_chk (
  input logic                    CLK,
  input logic                    reset,
  input logic                    uart_tx,
  input logic                    msg_done,
  input logic                    tx_active,
  input logic                    full,
  input logic                    empty,
  input logic                    wr_en,
  input logic                    rd_en,
  input uart_msg_pkg::baud_div_t div_q
);

  int fail_count = 0;
  int frame_cnt;
  int occ; // Shadow FIFO occupancy

  always_ff @(posedge CLK) begin
    if (reset) begin
      frame_cnt <= 0;
      occ       <= 0;
    end else begin
      frame_cnt <= tx_active ? frame_cnt + 1 : 0;
      occ       <= occ + int'(wr_en && !full) - int'(rd_en && !empty);
    end
  end

  line_idle: assert property (@(posedge CLK) disable iff (reset) !tx_active |-> uart_tx)
    else begin
      fail_count++;
      $error("uart_tx low while the transmitter is idle");
    end

  frame_len: assert property (@(posedge CLK) disable iff (reset)
      $fell(tx_active) |-> (frame_cnt == 10 * int'(div_q)))
    else begin
      fail_count++;
      $error("frame length differs from ten bit periods");
    end

  flags_excl: assert property (@(posedge CLK) disable iff (reset) !(full && empty))
    else begin
      fail_count++;
      $error("FIFO full and empty at the same time");
    end

  flags_level: assert property (@(posedge CLK) disable iff (reset)
      (full == (occ == `UART_FIFO_DEPTH)) && (empty == (occ == 0)))
    else begin
      fail_count++;
      $error("FIFO flags disagree with the entry count");
    end

  no_wr_full: assert property (@(posedge CLK) disable iff (reset) full |-> !wr_en)
    else begin
      fail_count++;
      $error("FIFO written while full");
    end

  done_pulse: assert property (@(posedge CLK) disable iff (reset) msg_done |=> !msg_done)
    else begin
      fail_count++;
      $error("msg_done held longer than one cycle");
    end

endmodule

bind uart_msg_top uart_msg_chk i_uart_msg_chk (
  .CLK       (CLK),
  .reset     (reset),
  .uart_tx   (uart_tx),
  .msg_done  (msg_done),
  .tx_active (tx_active),
  .full      (fifo_bus.full),
  .empty     (fifo_bus.empty),
  .wr_en     (fifo_bus.wr_en),
  .rd_en     (fifo_bus.rd_en),
  .div_q     (i_uart_tx.div_q)
);

//--- tb/uart_msg_tb.sv
`timescale 1ns/1ps
`include "uart_msg_defs.svh"

module uart_msg_tb;
  import uart_msg_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int LEN = `UART_MSG_LEN;
  // Frames of tests 2 to 5, doubled
  localparam int TIMEOUT_CYCLES = 2 * (LEN * 10 * 16 + LEN * 10 * 67 + 4 * LEN * 10 * 4);
  localparam cfg_addr_t ADDR_BAUD = cfg_addr_t'(`UART_ADDR_BAUD);
  localparam cfg_addr_t ADDR_CTRL = cfg_addr_t'(`UART_ADDR_CTRL);
  localparam cfg_addr_t ADDR_START = cfg_addr_t'(`UART_ADDR_START);
  localparam logic [8*13-1:0] GREETING = "Hello, Fifo!!";

  logic        CLK = 1'b0;
  logic        reset;
  logic        cfg_wr;
  cfg_addr_t   cfg_addr;
  logic [15:0] cfg_wdata;
  logic [15:0] cfg_rdata;
  logic        uart_tx;
  logic        busy;
  logic        msg_done;

  logic [31:0] lfsr = 32'hc4c4_33f9;
  int cur_div = `UART_BAUD_DIV_RESET; // Divisor the DUT should be using
  int cycles = 0;
  int errors = 0;
  int errors_at_start = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int done_count = 0;
  int frame_count = 0;
  int write_edge;
  int last_fall;
  int first_fall;
  int total_errors;
  logic saw_full;

  uart_msg_top i_uart_msg_top (
    .CLK       (CLK),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .uart_tx   (uart_tx),
    .busy      (busy),
    .msg_done  (msg_done)
  );

  initial begin
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  always @(negedge CLK) begin
    if (msg_done) done_count++;
    if (i_uart_msg_top.fifo_bus.full) saw_full = 1'b1;
  end

  // One count per start bit, data bit edges skipped
  always begin
    @(negedge uart_tx);
    frame_count++;
    repeat (10 * cur_div - cur_div / 2) @(negedge CLK); // Lands inside the stop bit
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never went idle", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  function automatic byte_t msg_byte(input int idx);
    if (idx < 13) return GREETING[8*(12-idx) +: 8];
    return (idx == 13) ? 8'h0d : 8'h0a; // CR LF tail
  endfunction

  task automatic random_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("[FAIL] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("At %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else report_mismatch(name, got, exp);
  endtask

  task automatic write_reg(input cfg_addr_t addr, input logic [15:0] data);
    @(negedge CLK);
    cfg_wr = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    @(posedge CLK);
    write_edge = int'($time);
    @(negedge CLK);
    cfg_wr = 1'b0;
    if (addr == ADDR_BAUD) begin
      cur_div = (data < 16'(`UART_BAUD_DIV_MIN)) ? `UART_BAUD_DIV_MIN : int'(data);
    end
  endtask

  task automatic check_reg(input cfg_addr_t addr, input logic [15:0] exp);
    @(negedge CLK);
    cfg_addr = addr;
    #1;
    check_value("cfg_rdata", int'(cfg_rdata), int'(exp));
  endtask

  task automatic recv_byte(output byte_t data);
    @(negedge uart_tx);
    last_fall = int'($time);
    repeat (cur_div / 2) @(negedge CLK); // Middle of the start bit
    assert (uart_tx == 1'b0) else report_problem("start bit not low at mid-bit");
    for (int i = 0; i < 8; i++) begin
      repeat (cur_div) @(negedge CLK);
      data[i] = uart_tx;
    end
    repeat (cur_div) @(negedge CLK);
    assert (uart_tx == 1'b1) else report_problem("stop bit not high at mid-bit");
  endtask

  task automatic recv_msg(input int count);
    byte_t b;
    for (int i = 0; i < count; i++) begin
      recv_byte(b);
      if (i == 0) first_fall = last_fall;
      check_value("uart_tx byte", int'(b), int'(msg_byte(i % LEN)));
    end
  endtask

  task automatic send_twice(input bit extra_start);
    write_reg(ADDR_BAUD, 16'd4);
    write_reg(ADDR_CTRL, 16'd1);
    write_reg(ADDR_START, 16'd0);
    fork
      recv_msg(2 * LEN);
      begin
        do @(negedge CLK); while (!msg_done);
        write_reg(ADDR_CTRL, 16'd0); // Second pass already started
        if (extra_start) write_reg(ADDR_START, 16'd0);
      end
    join
    while (busy) @(negedge CLK);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED with %0d errors", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin
    logic [31:0] r;
    logic [15:0] div;
    int done_before;
    int frames_before;
    cfg_wr = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    saw_full = 1'b0;
    reset = 1'b1;
    repeat (5) @(negedge CLK);
    reset = 1'b0;

    check_reg(ADDR_BAUD, 16'(`UART_BAUD_DIV_RESET));
    check_reg(ADDR_CTRL, 16'd0);
    check_reg(ADDR_START, 16'd0);
    check_value("uart_tx", int'(uart_tx), 1);
    check_value("busy", int'(busy), 0);
    check_value("msg_done", int'(msg_done), 0);
    finish_test("reset state");

    done_before = done_count;
    write_reg(ADDR_START, 16'd0);
    recv_msg(LEN);
    check_value("start delay cycles", (first_fall - write_edge) / CLK_PERIOD, 4);
    while (busy) @(negedge CLK);
    check_value("msg_done pulses", done_count - done_before, 1);
    finish_test("single message");

    write_reg(ADDR_BAUD, 16'd2);
    check_reg(ADDR_BAUD, 16'd4); // Clamped to minimum
    for (int i = 0; i < 3; i++) begin
      random_bits(6, r);
      div = 16'(r[5:0]) + 16'd4;
      write_reg(ADDR_BAUD, div);
      check_reg(ADDR_BAUD, div);
    end
    write_reg(ADDR_START, 16'd0);
    recv_msg(LEN);
    while (busy) @(negedge CLK);
    finish_test("divisor write and rate");

    saw_full = 1'b0;
    send_twice(1'b0);
    check_value("fifo full seen", int'(saw_full), 1);
    finish_test("back-pressure");

    done_before = done_count;
    frames_before = frame_count;
    send_twice(1'b1);
    check_value("msg_done pulses", done_count - done_before, 2);
    check_value("uart_tx frames", frame_count - frames_before, 2 * LEN);
    finish_test("repeat mode");

    total_errors = errors + i_uart_msg_top.i_uart_msg_chk.fail_count;
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+logic
logic/uart_msg_pkg.sv
logic/byte_fifo_if.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/msg_sender.sv
logic/tx_config.sv
logic/uart_msg_top.sv
tb/uart_msg_chk.sv
tb/uart_msg_tb.sv

//--- Makefile
# Verilator build and run of the UART message streamer testbench

SIM  := obj_dir/Vuart_msg_tb
SRCS := $(shell grep '\.sv$$' sources.f) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module uart_msg_tb -f sources.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
